//--- source/axi_wr_pkg.sv
// axi write buffer definitions
`default_nettype none

package axi_wr_pkg;

    // bus widths
    localparam int ID_W    = 4;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int LEN_W   = 8;
    localparam int BRESP_W = 2;

    // W beat storage
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    // data, strobe and last of one beat
    localparam int W_ENTRY_W  = DATA_W + STRB_W + 1;

    // host register port
    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 32;

    localparam logic [CFG_ADDR_W-1:0] REG_CTRL   = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_BURSTS = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_RESPS  = 2'd2;

    // address gate states
    localparam logic [1:0] AW_IDLE     = 2'd0;
    localparam logic [1:0] AW_XFER_IN  = 2'd1;
    localparam logic [1:0] AW_XFER_OUT = 2'd2;

endpackage

`default_nettype wire

//--- source/axi_wr_if.sv
// reduced axi write port
`timescale 1ns/1ps
`default_nettype none

interface axi_wr_if import axi_wr_pkg::*; ();

    // write address
    logic [ID_W-1:0]    awid;
    logic [ADDR_W-1:0]  awaddr;
    logic [LEN_W-1:0]   awlen;
    logic               awvalid;
    logic               awready;

    // write data
    logic [DATA_W-1:0]  wdata;
    logic [STRB_W-1:0]  wstrb;
    logic               wlast;
    logic               wvalid;
    logic               wready;

    // write response
    logic [ID_W-1:0]    bid;
    logic [BRESP_W-1:0] bresp;
    logic               bvalid;
    logic               bready;

    modport wr_mst (
        output awid, awaddr, awlen, awvalid,
        input  awready,
        output wdata, wstrb, wlast, wvalid,
        input  wready,
        input  bid, bresp, bvalid,
        output bready
    );

    modport wr_slv (
        input  awid, awaddr, awlen, awvalid,
        output awready,
        input  wdata, wstrb, wlast, wvalid,
        output wready,
        output bid, bresp, bvalid,
        input  bready
    );

endinterface

`default_nettype wire

//--- source/aw_gate.sv
// write address gate
`timescale 1ns/1ps
`default_nettype none

module aw_gate import axi_wr_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    axi_wr_if.wr_slv s_aw,
    axi_wr_if.wr_mst m_aw,
    input  logic     delay_en,
    input  logic     beat_acc,
    input  logic     beat_last,
    output logic     hold
);

    logic [1:0]         state_reg;
    logic [1:0]         state_next;
    logic               hold_reg;
    logic               hold_next;
    logic [FIFO_AW:0]   count_reg;
    logic [FIFO_AW:0]   count_next;
    logic               awready_reg;
    logic               awready_next;
    logic               awvalid_reg;
    logic               awvalid_next;
    logic [ID_W-1:0]    awid_reg;
    logic [ADDR_W-1:0]  awaddr_reg;
    logic [LEN_W-1:0]   awlen_reg;
    logic               bypass;
    logic               capture;

    // pass-through only when idle with nothing left to send
    assign bypass  = (state_reg == AW_IDLE) && !delay_en && !awvalid_reg;
    assign capture = s_aw.awvalid && awready_reg && delay_en;

    assign s_aw.awready = bypass ? m_aw.awready : (awready_reg && delay_en);
    assign m_aw.awvalid = bypass ? s_aw.awvalid : awvalid_reg;
    assign m_aw.awid    = bypass ? s_aw.awid : awid_reg;
    assign m_aw.awaddr  = bypass ? s_aw.awaddr : awaddr_reg;
    assign m_aw.awlen   = bypass ? s_aw.awlen : awlen_reg;
    assign hold         = bypass ? 1'b0 : hold_reg;

    always_comb begin
        state_next   = state_reg;
        hold_next    = hold_reg;
        count_next   = count_reg;
        awready_next = 1'b0;
        awvalid_next = awvalid_reg && !m_aw.awready;

        case (state_reg)
            AW_IDLE: begin
                hold_next    = 1'b1;
                awready_next = delay_en && (!awvalid_reg || m_aw.awready);
                if (capture) begin
                    awready_next = 1'b0;
                    hold_next    = 1'b0;
                    count_next   = '0;
                    state_next   = AW_XFER_IN;
                end
            end
            AW_XFER_IN: begin
                if (beat_acc) begin
                    count_next = count_reg + 1'b1;
                    if (beat_last) begin
                        awvalid_next = 1'b1;
                        hold_next    = 1'b1;
                        state_next   = AW_IDLE;
                    end else if (count_next == (FIFO_AW+1)'(FIFO_DEPTH)) begin
                        // fifo full, release the address early
                        awvalid_next = 1'b1;
                        state_next   = AW_XFER_OUT;
                    end
                end
            end
            AW_XFER_OUT: begin
                if (beat_acc && beat_last) begin
                    hold_next  = 1'b1;
                    state_next = AW_IDLE;
                end
            end
            default: begin
                state_next = AW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg   <= AW_IDLE;
            hold_reg    <= 1'b1;
            count_reg   <= '0;
            awready_reg <= 1'b0;
            awvalid_reg <= 1'b0;
        end else begin
            state_reg   <= state_next;
            hold_reg    <= hold_next;
            count_reg   <= count_next;
            awready_reg <= awready_next;
            awvalid_reg <= awvalid_next;
        end
    end

    // held address
    always_ff @(posedge clk) begin
        if (capture) begin
            awid_reg   <= s_aw.awid;
            awaddr_reg <= s_aw.awaddr;
            awlen_reg  <= s_aw.awlen;
        end
    end

endmodule

`default_nettype wire

//--- source/w_fifo.sv
// write data fifo
`timescale 1ns/1ps
`default_nettype none

module w_fifo import axi_wr_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    axi_wr_if.wr_slv s_w,
    axi_wr_if.wr_mst m_w,
    input  logic     hold,
    output logic     beat_acc,
    output logic     beat_last
);

    logic [W_ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW:0]     wr_ptr;
    logic [FIFO_AW:0]     rd_ptr;
    logic [W_ENTRY_W-1:0] rd_data;
    logic                 rd_valid;
    logic [W_ENTRY_W-1:0] out_data;
    logic                 out_valid;
    logic                 full;
    logic                 empty;
    logic                 wr_en;
    logic                 rd_en;
    logic                 out_load;

    // full when only the wrap bits differ
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign s_w.wready = !full && !hold;
    assign wr_en      = s_w.wvalid && s_w.wready;

    assign beat_acc  = wr_en;
    assign beat_last = s_w.wlast;

    // output stage takes a new beat when empty or draining
    assign out_load = m_w.wready || !out_valid;
    assign rd_en    = (out_load || !rd_valid) && !empty;

    assign m_w.wvalid = out_valid;
    assign {m_w.wlast, m_w.wstrb, m_w.wdata} = out_data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= {s_w.wlast, s_w.wstrb, s_w.wdata};
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr[FIFO_AW-1:0]];
        end
        if (out_load) begin
            out_data <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_load || !rd_valid) begin
                rd_valid <= !empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_load) begin
            out_valid <= rd_valid;
        end
    end

endmodule

`default_nettype wire

//--- source/buf_cfg.sv
// buffer control registers
`timescale 1ns/1ps
`default_nettype none

module buf_cfg import axi_wr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_req,
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output logic                  cfg_ack,
    input  logic                  beat_acc,
    input  logic                  beat_last,
    input  logic                  bvalid,
    input  logic                  bready,
    output logic                  delay_en
);

    logic                  ack_reg;
    logic                  ctrl_reg;
    logic [CFG_DATA_W-1:0] burst_cnt;
    logic [CFG_DATA_W-1:0] resp_cnt;
    logic [CFG_DATA_W-1:0] rdata_reg;
    logic                  access;
    logic                  wr_access;

    // one access per request, on the first edge with ack low
    assign access    = cfg_req && !ack_reg;
    assign wr_access = access && cfg_we;

    assign cfg_ack   = ack_reg;
    assign cfg_rdata = rdata_reg;
    assign delay_en  = ctrl_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_reg   <= 1'b0;
            ctrl_reg  <= 1'b0;
            burst_cnt <= '0;
            resp_cnt  <= '0;
        end else begin
            if (access) begin
                ack_reg <= 1'b1;
            end else if (!cfg_req) begin
                ack_reg <= 1'b0;
            end

            if (wr_access && cfg_addr == REG_CTRL) begin
                ctrl_reg <= cfg_wdata[0];
            end

            // a write clears, taking priority over counting
            if (wr_access && cfg_addr == REG_BURSTS) begin
                burst_cnt <= '0;
            end else if (beat_acc && beat_last) begin
                burst_cnt <= burst_cnt + 1'b1;
            end

            if (wr_access && cfg_addr == REG_RESPS) begin
                resp_cnt <= '0;
            end else if (bvalid && bready) begin
                resp_cnt <= resp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (cfg_addr)
                REG_CTRL:   rdata_reg <= {{(CFG_DATA_W-1){1'b0}}, ctrl_reg};
                REG_BURSTS: rdata_reg <= burst_cnt;
                REG_RESPS:  rdata_reg <= resp_cnt;
                default:    rdata_reg <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/axi_wr_buffer.sv
// axi write channel buffer
`timescale 1ns/1ps
`default_nettype none

module axi_wr_buffer import axi_wr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // upstream master side
    input  logic [ID_W-1:0]       s_awid,
    input  logic [ADDR_W-1:0]     s_awaddr,
    input  logic [LEN_W-1:0]      s_awlen,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [DATA_W-1:0]     s_wdata,
    input  logic [STRB_W-1:0]     s_wstrb,
    input  logic                  s_wlast,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [ID_W-1:0]       s_bid,
    output logic [BRESP_W-1:0]    s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,

    // downstream slave side
    output logic [ID_W-1:0]       m_awid,
    output logic [ADDR_W-1:0]     m_awaddr,
    output logic [LEN_W-1:0]      m_awlen,
    output logic                  m_awvalid,
    input  logic                  m_awready,
    output logic [DATA_W-1:0]     m_wdata,
    output logic [STRB_W-1:0]     m_wstrb,
    output logic                  m_wlast,
    output logic                  m_wvalid,
    input  logic                  m_wready,
    input  logic [ID_W-1:0]       m_bid,
    input  logic [BRESP_W-1:0]    m_bresp,
    input  logic                  m_bvalid,
    output logic                  m_bready,

    // host register port
    input  logic                  cfg_req,
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output logic                  cfg_ack
);

    logic delay_en;
    logic hold;
    logic beat_acc;
    logic beat_last;

    axi_wr_if s_bus ();
    axi_wr_if m_bus ();

    // upstream ports into s_bus
    assign s_bus.awid    = s_awid;
    assign s_bus.awaddr  = s_awaddr;
    assign s_bus.awlen   = s_awlen;
    assign s_bus.awvalid = s_awvalid;
    assign s_awready     = s_bus.awready;
    assign s_bus.wdata   = s_wdata;
    assign s_bus.wstrb   = s_wstrb;
    assign s_bus.wlast   = s_wlast;
    assign s_bus.wvalid  = s_wvalid;
    assign s_wready      = s_bus.wready;
    assign s_bid         = s_bus.bid;
    assign s_bresp       = s_bus.bresp;
    assign s_bvalid      = s_bus.bvalid;
    assign s_bus.bready  = s_bready;

    // m_bus out to downstream ports
    assign m_awid        = m_bus.awid;
    assign m_awaddr      = m_bus.awaddr;
    assign m_awlen       = m_bus.awlen;
    assign m_awvalid     = m_bus.awvalid;
    assign m_bus.awready = m_awready;
    assign m_wdata       = m_bus.wdata;
    assign m_wstrb       = m_bus.wstrb;
    assign m_wlast       = m_bus.wlast;
    assign m_wvalid      = m_bus.wvalid;
    assign m_bus.wready  = m_wready;
    assign m_bus.bid     = m_bid;
    assign m_bus.bresp   = m_bresp;
    assign m_bus.bvalid  = m_bvalid;
    assign m_bready      = m_bus.bready;

    // response channel passes straight through
    assign s_bus.bid    = m_bus.bid;
    assign s_bus.bresp  = m_bus.bresp;
    assign s_bus.bvalid = m_bus.bvalid;
    assign m_bus.bready = s_bus.bready;

    aw_gate aw_gate_i (
        .clk       (clk),
        .rst       (rst),
        .s_aw      (s_bus),
        .m_aw      (m_bus),
        .delay_en  (delay_en),
        .beat_acc  (beat_acc),
        .beat_last (beat_last),
        .hold      (hold)
    );

    w_fifo w_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .s_w       (s_bus),
        .m_w       (m_bus),
        .hold      (hold),
        .beat_acc  (beat_acc),
        .beat_last (beat_last)
    );

    buf_cfg buf_cfg_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_req   (cfg_req),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg_ack   (cfg_ack),
        .beat_acc  (beat_acc),
        .beat_last (beat_last),
        .bvalid    (m_bus.bvalid),
        .bready    (s_bus.bready),
        .delay_en  (delay_en)
    );

endmodule

`default_nettype wire

//--- bench/tb_axi_wr_buffer.sv
// write buffer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_buffer import axi_wr_pkg::*; ();

    localparam int          PERIOD     = 100;
    localparam int          N_BURSTS   = 20;
    localparam int          N_TOTAL    = 2 * N_BURSTS;
    localparam int          TIMEOUT_NS = N_TOTAL * 40 * PERIOD + 50000;
    localparam logic [31:0] SEED       = 32'h2228a399;

    logic                  clk;
    logic                  rst;
    logic [ID_W-1:0]       s_awid;
    logic [ADDR_W-1:0]     s_awaddr;
    logic [LEN_W-1:0]      s_awlen;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [DATA_W-1:0]     s_wdata;
    logic [STRB_W-1:0]     s_wstrb;
    logic                  s_wlast;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [ID_W-1:0]       s_bid;
    logic [BRESP_W-1:0]    s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic [ID_W-1:0]       m_awid;
    logic [ADDR_W-1:0]     m_awaddr;
    logic [LEN_W-1:0]      m_awlen;
    logic                  m_awvalid;
    logic                  m_awready;
    logic [DATA_W-1:0]     m_wdata;
    logic [STRB_W-1:0]     m_wstrb;
    logic                  m_wlast;
    logic                  m_wvalid;
    logic                  m_wready;
    logic [ID_W-1:0]       m_bid;
    logic [BRESP_W-1:0]    m_bresp;
    logic                  m_bvalid;
    logic                  m_bready;
    logic                  cfg_req;
    logic                  cfg_we;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_wdata;
    logic [CFG_DATA_W-1:0] cfg_rdata;
    logic                  cfg_ack;

    int          error_count;
    int          check_count;
    logic        delay_mode;
    logic        m_aw_seen;
    logic [31:0] main_rng;
    logic [31:0] aw_rng;
    logic [31:0] w_rng;
    logic [31:0] slv_rng;

    // burst plan and per-burst progress
    logic [LEN_W-1:0]  b_len  [N_TOTAL];
    logic [ID_W-1:0]   b_id   [N_TOTAL];
    logic [ADDR_W-1:0] b_addr [N_TOTAL];
    int                beats_exp [N_TOTAL];
    int                acc_beats [N_TOTAL];

    // reference model and slave model queues
    logic [ID_W+ADDR_W+LEN_W-1:0] exp_aw_q [$];
    logic [W_ENTRY_W-1:0]         exp_w_q [$];
    logic [ID_W+BRESP_W-1:0]      exp_b_q [$];
    logic [ID_W+BRESP_W-1:0]      slv_b_q [$];
    int up_aw_cnt;
    int up_w_burst;
    int down_aw_cnt;
    int slv_wlast_cnt;
    int up_b_cnt;
    int model_bursts;
    int model_resps;

    axi_wr_buffer dut_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: traffic or register access did not finish within %0d ns", TIMEOUT_NS);
        error_count++;
        finish_run();
    end

    // downstream and response ready stalls
    always @(negedge clk) begin
        slv_rng = xorshift(slv_rng);
        m_awready = slv_rng[1:0] != 2'd0;
        m_wready  = slv_rng[3:2] != 2'd0;
        s_bready  = slv_rng[5:4] != 2'd0;
    end

    // slave returns one response per burst, in order
    initial begin
        forever begin
            @(negedge clk);
            m_bvalid = 1'b0;
            if (slv_b_q.size() > 0 && slv_wlast_cnt > 0) begin
                {m_bid, m_bresp} = slv_b_q.pop_front();
                slv_wlast_cnt--;
                m_bvalid = 1'b1;
                @(posedge clk);
                while (!m_bready) @(posedge clk);
            end
        end
    end

    always @(posedge clk) begin : monitor
        int                           need;
        logic [ID_W+ADDR_W+LEN_W-1:0] aw_exp;
        logic [W_ENTRY_W-1:0]         w_exp;
        logic [ID_W+BRESP_W-1:0]      b_exp;
        if (!rst) begin
            check_count++;
            if ({s_bvalid, m_bready} !== {m_bvalid, s_bready}) begin
                $display("ERROR s_bvalid/m_bready: got %h, expected %h",
                         {s_bvalid, m_bready}, {m_bvalid, s_bready});
                error_count++;
            end
            if (m_bvalid && {s_bid, s_bresp} !== {m_bid, m_bresp}) begin
                $display("ERROR s_bid/s_bresp: got %h, expected %h",
                         {s_bid, s_bresp}, {m_bid, m_bresp});
                error_count++;
            end
            // address ready passes straight through in bypass
            if (!delay_mode && s_awvalid && s_awready !== m_awready) begin
                $display("ERROR s_awready: got %h, expected %h", s_awready, m_awready);
                error_count++;
            end
            if (delay_mode && s_awready &&
                (up_aw_cnt != down_aw_cnt || up_aw_cnt != up_w_burst)) begin
                $display("s_awready is high while a burst is still in flight");
                error_count++;
            end
            if (delay_mode && s_wready && up_aw_cnt <= up_w_burst) begin
                $display("s_wready is high while no write address is pending");
                error_count++;
            end
            // address release point against stored beats
            if (delay_mode && m_awvalid && !m_aw_seen) begin
                m_aw_seen = 1'b1;
                need = beats_exp[down_aw_cnt];
                if (need > FIFO_DEPTH) begin
                    need = FIFO_DEPTH;
                end
                check_count++;
                if (acc_beats[down_aw_cnt] < need) begin
                    $display("address of burst %0d released after %0d beats, needed %0d",
                             down_aw_cnt, acc_beats[down_aw_cnt], need);
                    error_count++;
                end
            end
            if (s_wvalid && s_wready) begin
                if (delay_mode && up_aw_cnt <= up_w_burst) begin
                    $display("a write beat was accepted before its address");
                    error_count++;
                end
                exp_w_q.push_back({s_wlast, s_wstrb, s_wdata});
                acc_beats[up_w_burst]++;
                if (s_wlast) begin
                    up_w_burst++;
                    model_bursts++;
                end
            end
            if (s_awvalid && s_awready) begin
                exp_aw_q.push_back({s_awid, s_awaddr, s_awlen});
                exp_b_q.push_back({s_awid, s_awaddr[BRESP_W-1:0]});
                beats_exp[up_aw_cnt] = s_awlen + 1;
                up_aw_cnt++;
            end
            if (m_awvalid && m_awready) begin
                check_count++;
                if (exp_aw_q.size() == 0) begin
                    $display("downstream address seen with no upstream address to match");
                    error_count++;
                end else begin
                    aw_exp = exp_aw_q.pop_front();
                    if ({m_awid, m_awaddr, m_awlen} !== aw_exp) begin
                        $display("ERROR m_awid/m_awaddr/m_awlen: got %h, expected %h",
                                 {m_awid, m_awaddr, m_awlen}, aw_exp);
                        error_count++;
                    end
                end
                slv_b_q.push_back({m_awid, m_awaddr[BRESP_W-1:0]});
                down_aw_cnt++;
                m_aw_seen = 1'b0;
            end
            if (m_wvalid && m_wready) begin
                check_count++;
                if (exp_w_q.size() == 0) begin
                    $display("downstream write beat seen with no upstream beat to match");
                    error_count++;
                end else begin
                    w_exp = exp_w_q.pop_front();
                    if ({m_wlast, m_wstrb, m_wdata} !== w_exp) begin
                        $display("ERROR m_wlast/m_wstrb/m_wdata: got %h, expected %h",
                                 {m_wlast, m_wstrb, m_wdata}, w_exp);
                        error_count++;
                    end
                end
                if (m_wlast) begin
                    slv_wlast_cnt++;
                end
            end
            if (s_bvalid && s_bready) begin
                check_count++;
                if (exp_b_q.size() == 0) begin
                    $display("upstream response seen with no burst outstanding");
                    error_count++;
                end else begin
                    b_exp = exp_b_q.pop_front();
                    if ({s_bid, s_bresp} !== b_exp) begin
                        $display("ERROR s_bid/s_bresp: got %h, expected %h",
                                 {s_bid, s_bresp}, b_exp);
                        error_count++;
                    end
                end
                model_resps++;
                up_b_cnt++;
            end
        end
    end

    // four-phase host access, entered and left on a falling edge
    task automatic host_access(input logic we, input logic [CFG_ADDR_W-1:0] addr,
                               input logic [CFG_DATA_W-1:0] wdata,
                               output logic [CFG_DATA_W-1:0] rdata);
        cfg_we    = we;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        cfg_req   = 1'b1;
        @(posedge clk);
        while (!cfg_ack) @(posedge clk);
        rdata = cfg_rdata;
        @(negedge clk);
        cfg_req = 1'b0;
        @(posedge clk);
        check_count++;
        if (!cfg_ack) begin
            $display("cfg_ack dropped before cfg_req was released");
            error_count++;
        end
        while (cfg_ack) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic reg_write(input logic [CFG_ADDR_W-1:0] addr,
                             input logic [CFG_DATA_W-1:0] data);
        logic [CFG_DATA_W-1:0] unused;
        host_access(1'b1, addr, data, unused);
    endtask

    task automatic reg_expect(input logic [CFG_ADDR_W-1:0] addr,
                              input logic [CFG_DATA_W-1:0] expected);
        logic [CFG_DATA_W-1:0] rd;
        host_access(1'b0, addr, '0, rd);
        check_count++;
        if (rd !== expected) begin
            $display("ERROR cfg_rdata: got %h, expected %h (address %h)", rd, expected, addr);
            error_count++;
        end
    endtask

    task automatic counters_check_clear();
        reg_expect(REG_BURSTS, model_bursts);
        reg_expect(REG_RESPS, model_resps);
        reg_write(REG_BURSTS, 32'hffff_ffff);
        model_bursts = 0;
        reg_write(REG_RESPS, 32'h0000_0001);
        model_resps = 0;
        reg_expect(REG_BURSTS, 32'd0);
        reg_expect(REG_RESPS, 32'd0);
    endtask

    task automatic send_addresses(input int first);
        int i;
        for (i = first; i < first + N_BURSTS; i++) begin
            aw_rng = xorshift(aw_rng);
            if (aw_rng[1:0] == 2'd0) begin
                s_awvalid = 1'b0;
                @(negedge clk);
            end
            s_awid    = b_id[i];
            s_awaddr  = b_addr[i];
            s_awlen   = b_len[i];
            s_awvalid = 1'b1;
            @(posedge clk);
            while (!s_awready) @(posedge clk);
            @(negedge clk);
        end
        s_awvalid = 1'b0;
    endtask

    task automatic send_beats(input int first);
        int i;
        int j;
        for (i = first; i < first + N_BURSTS; i++) begin
            for (j = 0; j <= b_len[i]; j++) begin
                w_rng = xorshift(w_rng);
                if (w_rng[1:0] == 2'd0) begin
                    s_wvalid = 1'b0;
                    @(negedge clk);
                end
                s_wstrb  = w_rng[STRB_W+7:8];
                w_rng    = xorshift(w_rng);
                s_wdata  = w_rng;
                s_wlast  = (j == b_len[i]);
                s_wvalid = 1'b1;
                @(posedge clk);
                while (!s_wready) @(posedge clk);
                @(negedge clk);
            end
        end
        s_wvalid = 1'b0;
    endtask

    task automatic run_bursts(input int first);
        int i;
        for (i = first; i < first + N_BURSTS; i++) begin
            main_rng  = xorshift(main_rng);
            b_len[i]  = main_rng[7:0] % 24;
            b_id[i]   = main_rng[11:8];
            main_rng  = xorshift(main_rng);
            b_addr[i] = main_rng;
        end
        fork
            send_addresses(first);
            send_beats(first);
        join
        while (up_b_cnt < first + N_BURSTS) @(negedge clk);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst        = 1'b1;
        s_awid     = '0;
        s_awaddr   = '0;
        s_awlen    = '0;
        s_awvalid  = 1'b0;
        s_wdata    = '0;
        s_wstrb    = '0;
        s_wlast    = 1'b0;
        s_wvalid   = 1'b0;
        s_bready   = 1'b0;
        m_awready  = 1'b0;
        m_wready   = 1'b0;
        m_bid      = '0;
        m_bresp    = '0;
        m_bvalid   = 1'b0;
        cfg_req    = 1'b0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        delay_mode = 1'b0;
        m_aw_seen  = 1'b0;
        main_rng   = SEED;
        aw_rng     = xorshift(SEED ^ 32'h0000_00a5);
        w_rng      = xorshift(SEED ^ 32'h0000_5a00);
        slv_rng    = xorshift(SEED ^ 32'h00c3_0000);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // pass-through mode
        reg_expect(REG_CTRL, 32'd0);
        run_bursts(0);
        counters_check_clear();

        // address held until data stored
        reg_write(REG_CTRL, 32'd1);
        reg_expect(REG_CTRL, 32'd1);
        delay_mode = 1'b1;
        run_bursts(N_BURSTS);

        // unmapped address, while both counters are nonzero
        reg_expect(2'd3, 32'd0);
        reg_write(2'd3, 32'hffff_fffe);
        reg_expect(2'd3, 32'd0);
        reg_expect(REG_CTRL, 32'd1);
        counters_check_clear();
        finish_run();
    end

endmodule

`default_nettype wire

//--- list.f
source/axi_wr_pkg.sv
source/axi_wr_if.sv
source/aw_gate.sv
source/w_fifo.sv
source/buf_cfg.sv
source/axi_wr_buffer.sv
bench/tb_axi_wr_buffer.sv

//--- Bender.yml
package:
  name: axi_wr_buffer

sources:
  - source/axi_wr_pkg.sv
  - source/axi_wr_if.sv
  - source/aw_gate.sv
  - source/w_fifo.sv
  - source/buf_cfg.sv
  - source/axi_wr_buffer.sv
  - target: test
    files:
      - bench/tb_axi_wr_buffer.sv
